/* hdl/mz_config.svh */
`ifndef MZ_CONFIG_SVH
`define MZ_CONFIG_SVH

// --------------------
// Host bus
// --------------------
`define MZ_ADDR_W 24          // Mezzanine address width
`define MZ_DATA_W 32          // Bus data width
`define MZ_LANES 4            // Byte lanes per word

// --------------------
// Buffer RAM and map
// --------------------
`define MZ_RAM_IDX_W 9        // 512 words
`define MZ_REG_PAGE 4'h0      // Value of addr[15:12] for the register page

// Strobe input stages before the level qualifier
`define MZ_SYNC_STAGES 2

`endif

/* hdl/mz_bus_pkg.sv */
`default_nettype none
`include "mz_config.svh"

package mz_bus_pkg;

  typedef logic [`MZ_ADDR_W-1:0] bus_addr_t;  // Latched host address
  typedef logic [`MZ_DATA_W-1:0] bus_data_t;  // One bus word
  typedef logic [7:0]            reg_off_t;   // Offset inside register page

  // Bus sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,       // Waiting for strobe
    SEQ_DECODE,     // Address latched
    SEQ_ACCESS,     // Register, RAM or sum access
    SEQ_READ_WAIT,  // RAM read data arrives
    SEQ_ACK,        // Raise DTACK
    SEQ_HOLD_ACK    // DTACK high until strobe drops
  } seq_state_t;

  // Decoder control register offsets
  localparam reg_off_t REG_RUN    = 8'h00;  // Start level in bit 0
  localparam reg_off_t REG_NCS    = 8'h10;  // Coding scheme
  localparam reg_off_t REG_NCT    = 8'h14;  // Channel type
  localparam reg_off_t REG_N1     = 8'h18;
  localparam reg_off_t REG_N2     = 8'h1c;
  localparam reg_off_t REG_NNOBPA = 8'h20;  // Out bits part A
  localparam reg_off_t REG_NNOBPB = 8'h24;  // Out bits part B
  localparam reg_off_t REG_PPPA   = 8'h28;  // Puncture pattern A
  localparam reg_off_t REG_PPPB   = 8'h2c;  // Puncture pattern B
  localparam reg_off_t REG_LVL    = 8'h30;  // Level

endpackage

`default_nettype wire

/* hdl/mz_mem_pkg.sv */
`default_nettype none
`include "mz_config.svh"

package mz_mem_pkg;

  // --------------------
  // Buffer RAM types
  // --------------------
  typedef logic [`MZ_DATA_W-1:0]    ram_word_t;  // One RAM word
  typedef logic [`MZ_RAM_IDX_W-1:0] ram_idx_t;   // Word index
  typedef logic [`MZ_LANES-1:0]     byte_en_t;   // Lane write enables

  // Sum function word map
  localparam ram_idx_t SUM_TRIGGER_IDX = ram_idx_t'(0);  // Read returns A + B
  localparam ram_idx_t SUM_A_IDX       = ram_idx_t'(1);  // First operand
  localparam ram_idx_t SUM_B_IDX       = ram_idx_t'(2);  // Second operand

endpackage

`default_nettype wire

/* hdl/mem_port_if.sv */
`default_nettype none

// One requester's view of the shared buffer RAM
interface mem_port_if (
  input logic clk  // Arbiter clock
);
  import mz_mem_pkg::*;

  logic      req;    // Held until gnt
  byte_en_t  we;     // Lane writes and all zero on read
  ram_idx_t  idx;    // Word index
  ram_word_t wdata;  // Write word
  ram_word_t rdata;  // Valid the cycle after gnt
  logic      gnt;    // Access happens this cycle

  modport requester (
    output req,
    output we,
    output idx,
    output wdata,
    input  rdata,
    input  gnt
  );

  modport arbiter (
    input  clk,
    input  req,
    input  we,
    input  idx,
    input  wdata,
    output rdata,
    output gnt
  );

endinterface

`default_nettype wire

/* hdl/mz_bus_slave.sv */
`default_nettype none
`include "mz_config.svh"

module mz_bus_slave (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bus_as,      // Address strobe level
  input  logic                  bus_rw,      // High for read
  input  logic [`MZ_LANES-1:0]  bus_byte_n,  // Active-low lanes
  input  logic [`MZ_ADDR_W-1:0] bus_addr,
  input  mz_bus_pkg::bus_data_t bus_wdata,
  output mz_bus_pkg::bus_data_t bus_rdata,
  output logic                  bus_rdata_oe,
  output logic                  bus_dtack,
  output logic                  reg_wr,      // One-cycle write strobe
  output mz_bus_pkg::reg_off_t  reg_off,
  output mz_bus_pkg::bus_data_t reg_wdata,
  input  mz_bus_pkg::bus_data_t reg_rdata,
  mem_port_if.requester         host,        // Host path to buffer RAM
  output logic                  sum_start,   // One-cycle pulse
  input  logic                  sum_done,
  input  mz_mem_pkg::ram_word_t sum_result
);
  import mz_bus_pkg::*;
  import mz_mem_pkg::*;

  logic [`MZ_SYNC_STAGES-1:0] as_sync;   // Strobe synchronizer
  logic                       as_det;    // Qualified strobe
  seq_state_t                 state;
  seq_state_t                 state_nxt;
  logic                       dtack_q;
  bus_addr_t                  addr_q;    // Latched at strobe
  bus_data_t                  wdata_q;
  logic [`MZ_LANES-1:0]       byte_n_q;
  logic                       rw_q;
  bus_data_t                  rdata_q;   // Returned read word
  ram_idx_t                   word_idx;
  logic                       sel_reg;   // Register page hit
  logic                       sel_sum;   // Read of sum trigger word

  // --------------------
  // Strobe detect
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      as_sync <= '0;
    end else begin
      as_sync <= {as_sync[`MZ_SYNC_STAGES-2:0], bus_as};  // Shift in raw strobe
    end
  end

  assign as_det = (&as_sync) && bus_as;  // Rise is late, fall is immediate

  // Address decode on latched fields
  assign word_idx = addr_q[`MZ_RAM_IDX_W+1:2];             // Word address
  assign sel_reg  = (addr_q[15:12] == `MZ_REG_PAGE);
  assign sel_sum  = !sel_reg && rw_q && (word_idx == SUM_TRIGGER_IDX);

  // --------------------
  // Sequencer
  // --------------------
  always_comb begin
    state_nxt = state;
    case (state)
      SEQ_IDLE: begin
        if (as_det) begin
          state_nxt = SEQ_DECODE;
        end
      end
      SEQ_DECODE: state_nxt = SEQ_ACCESS;
      SEQ_ACCESS: begin
        if (sel_reg) begin
          state_nxt = SEQ_ACK;                             // Registers take one cycle
        end else if (sel_sum) begin
          if (sum_done) begin
            state_nxt = SEQ_ACK;
          end
        end else if (host.gnt) begin
          state_nxt = rw_q ? SEQ_READ_WAIT : SEQ_ACK;      // Read data next cycle
        end
      end
      SEQ_READ_WAIT: state_nxt = SEQ_ACK;
      SEQ_ACK:       state_nxt = SEQ_HOLD_ACK;
      SEQ_HOLD_ACK: begin
        if (!as_det) begin
          state_nxt = SEQ_IDLE;                            // Host dropped strobe
        end
      end
      default: state_nxt = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= SEQ_IDLE;
      dtack_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == SEQ_ACK) begin
        dtack_q <= 1'b1;                                   // Raise DTACK
      end else if (state_nxt == SEQ_IDLE) begin
        dtack_q <= 1'b0;                                   // Drop with strobe
      end
    end
  end

  // Latched bus fields and read capture
  always_ff @(posedge clk) begin
    case (state)
      SEQ_IDLE: begin
        if (as_det) begin
          addr_q   <= bus_addr;
          wdata_q  <= bus_wdata;
          byte_n_q <= bus_byte_n;
          rw_q     <= bus_rw;
        end
      end
      SEQ_ACCESS: begin
        if (sel_reg) begin
          rdata_q <= reg_rdata;                            // Register readback
        end else if (sel_sum && sum_done) begin
          rdata_q <= sum_result;
        end
      end
      SEQ_READ_WAIT: rdata_q <= host.rdata;                // RAM word
      default: ;
    endcase
  end

  // Register strobes
  assign reg_wr    = (state == SEQ_ACCESS) && sel_reg && !rw_q;
  assign reg_off   = addr_q[7:0];
  assign reg_wdata = wdata_q;                              // Full word

  // Sum trigger and RAM request
  assign sum_start  = (state == SEQ_DECODE) && sel_sum;
  assign host.req   = (state == SEQ_ACCESS) && !sel_reg && !sel_sum;
  assign host.we    = rw_q ? '0 : ~byte_n_q;               // Low byte_n lanes only
  assign host.idx   = word_idx;
  assign host.wdata = wdata_q;

  // Bus outputs
  assign bus_rdata    = rdata_q;
  assign bus_rdata_oe = bus_as && bus_rw;                  // Drive while read strobe high
  assign bus_dtack    = dtack_q;

  a_no_dtack_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SEQ_IDLE) |-> !bus_dtack);

endmodule

`default_nettype wire

/* hdl/ctrl_regs.sv */
`default_nettype none

module ctrl_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reg_wr,
  input  mz_bus_pkg::reg_off_t  reg_off,
  input  mz_bus_pkg::bus_data_t reg_wdata,
  output mz_bus_pkg::bus_data_t reg_rdata,  // Zero on unmapped offset
  output logic                  ctrl_run     // Decoder start level
);
  import mz_bus_pkg::*;

  localparam int NUM_REGS = 10;

  bus_data_t  regs_q [NUM_REGS];  // Run then nine arguments
  logic [3:0] sel;                // Register slot
  logic       hit;                // Offset is mapped

  // Offset decode
  always_comb begin
    hit = 1'b1;
    sel = 4'd0;
    case (reg_off)
      REG_RUN:    sel = 4'd0;
      REG_NCS:    sel = 4'd1;
      REG_NCT:    sel = 4'd2;
      REG_N1:     sel = 4'd3;
      REG_N2:     sel = 4'd4;
      REG_NNOBPA: sel = 4'd5;
      REG_NNOBPB: sel = 4'd6;
      REG_PPPA:   sel = 4'd7;
      REG_PPPB:   sel = 4'd8;
      REG_LVL:    sel = 4'd9;
      default:    hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (reg_wr && hit) begin
      regs_q[sel] <= reg_wdata;   // Full-word write
    end
  end

  assign reg_rdata = hit ? regs_q[sel] : '0;
  assign ctrl_run  = regs_q[0][0];  // Run register bit 0

endmodule

`default_nettype wire

/* hdl/ram_arbiter.sv */
`default_nettype none

module ram_arbiter (
  mem_port_if.arbiter           host,       // Bus slave requests
  mem_port_if.arbiter           eng,        // Sum engine requests
  output logic                  ram_en,
  output mz_mem_pkg::byte_en_t  ram_we,
  output mz_mem_pkg::ram_idx_t  ram_idx,
  output mz_mem_pkg::ram_word_t ram_wdata,
  input  mz_mem_pkg::ram_word_t ram_rdata
);

  // --------------------
  // Grant
  // --------------------
  assign eng.gnt  = eng.req;                // Engine first
  assign host.gnt = host.req && !eng.req;   // Host when engine is quiet

  // Forward the winner to the RAM
  always_comb begin
    ram_en    = eng.req || host.req;
    ram_we    = '0;
    ram_idx   = host.idx;
    ram_wdata = host.wdata;
    if (eng.gnt) begin
      ram_we    = eng.we;
      ram_idx   = eng.idx;
      ram_wdata = eng.wdata;
    end else if (host.gnt) begin
      ram_we = host.we;                     // Host fields already on the mux
    end
  end

  // Shared read data
  // Only the port granted last cycle samples it
  assign host.rdata = ram_rdata;
  assign eng.rdata  = ram_rdata;

  // Waiting host keeps its request and fields
  a_host_hold: assert property (@(posedge host.clk)
    (host.req && !host.gnt) |=>
      (host.req && $stable(host.idx) && $stable(host.we) && $stable(host.wdata)));

endmodule

`default_nettype wire

/* hdl/word_ram.sv */
`default_nettype none
`include "mz_config.svh"

module word_ram (
  input  logic                  clk,
  input  logic                  en,     // Access this cycle
  input  mz_mem_pkg::byte_en_t  we,     // Lane writes
  input  mz_mem_pkg::ram_idx_t  idx,
  input  mz_mem_pkg::ram_word_t wdata,
  output mz_mem_pkg::ram_word_t rdata   // One cycle after en
);
  import mz_mem_pkg::*;

  localparam int DEPTH = 2 ** `MZ_RAM_IDX_W;

  ram_word_t mem [DEPTH];  // Buffer storage

  // --------------------
  // Lane write and read
  // --------------------
  always_ff @(posedge clk) begin
    if (en) begin
      for (int lane = 0; lane < `MZ_LANES; lane++) begin
        if (we[lane]) begin
          mem[idx][lane*8 +: 8] <= wdata[lane*8 +: 8];  // One byte lane
        end
      end
      rdata <= mem[idx];  // Old word on a write
    end
  end

endmodule

`default_nettype wire

/* hdl/sum_engine.sv */
`default_nettype none

module sum_engine (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sum_start,   // One-cycle pulse
  output logic                  sum_done,    // One-cycle pulse
  output mz_mem_pkg::ram_word_t sum_result,  // Valid with sum_done
  mem_port_if.requester         mem          // Engine path to buffer RAM
);
  import mz_mem_pkg::*;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_RD_A,    // Request word A
    ENG_WAIT_A,  // Word A on rdata
    ENG_RD_B,    // Request word B
    ENG_WAIT_B   // Word B on rdata and result out
  } eng_state_t;

  eng_state_t state;
  ram_word_t  op_a;   // First operand

  // --------------------
  // Fetch sequence
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ENG_IDLE;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (sum_start) begin
            state <= ENG_RD_A;
          end
        end
        ENG_RD_A: begin
          if (mem.gnt) begin
            state <= ENG_WAIT_A;
          end
        end
        ENG_WAIT_A: state <= ENG_RD_B;
        ENG_RD_B: begin
          if (mem.gnt) begin
            state <= ENG_WAIT_B;
          end
        end
        ENG_WAIT_B: state <= ENG_IDLE;
        default:    state <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ENG_WAIT_A) begin
      op_a <= mem.rdata;  // Hold word A
    end
  end

  // Read-only requester
  assign mem.req   = (state == ENG_RD_A) || (state == ENG_RD_B);
  assign mem.we    = '0;
  assign mem.idx   = (state == ENG_RD_B) ? SUM_B_IDX : SUM_A_IDX;
  assign mem.wdata = '0;

  assign sum_done   = (state == ENG_WAIT_B);
  assign sum_result = op_a + mem.rdata;  // Wraps at 32 bits

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    sum_start |-> (state == ENG_IDLE));

endmodule

`default_nettype wire

/* hdl/mz_top.sv */
`default_nettype none
`include "mz_config.svh"

module mz_top (
  input  logic                  FPGA_CLK3,
  input  logic                  SYS_RST_N,
  input  logic                  bus_as,
  input  logic                  bus_rw,
  input  logic [`MZ_LANES-1:0]  bus_byte_n,
  input  logic [`MZ_ADDR_W-1:0] bus_addr,
  input  logic [`MZ_DATA_W-1:0] bus_wdata,
  output logic [`MZ_DATA_W-1:0] bus_rdata,
  output logic                  bus_rdata_oe,
  output logic                  bus_dtack,
  output logic                  ctrl_run
);
  import mz_bus_pkg::*;
  import mz_mem_pkg::*;

  // --------------------
  // Internal wires
  // --------------------
  logic      reg_wr;
  reg_off_t  reg_off;
  bus_data_t reg_wdata;
  bus_data_t reg_rdata;
  logic      sum_start;
  logic      sum_done;
  ram_word_t sum_result;
  logic      ram_en;
  byte_en_t  ram_we;
  ram_idx_t  ram_idx;
  ram_word_t ram_wdata;
  ram_word_t ram_rdata;

  mem_port_if host_port (.clk(FPGA_CLK3));  // Bus slave side
  mem_port_if eng_port  (.clk(FPGA_CLK3));  // Sum engine side

  mz_bus_slave u_bus_slave (
    .clk          (FPGA_CLK3),
    .rst_n        (SYS_RST_N),
    .bus_as       (bus_as),
    .bus_rw       (bus_rw),
    .bus_byte_n   (bus_byte_n),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .bus_rdata    (bus_rdata),
    .bus_rdata_oe (bus_rdata_oe),
    .bus_dtack    (bus_dtack),
    .reg_wr       (reg_wr),
    .reg_off      (reg_off),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .host         (host_port.requester),
    .sum_start    (sum_start),
    .sum_done     (sum_done),
    .sum_result   (sum_result)
  );

  ctrl_regs u_ctrl_regs (
    .clk       (FPGA_CLK3),
    .rst_n     (SYS_RST_N),
    .reg_wr    (reg_wr),
    .reg_off   (reg_off),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .ctrl_run  (ctrl_run)
  );

  ram_arbiter u_ram_arbiter (
    .host      (host_port.arbiter),
    .eng       (eng_port.arbiter),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_idx   (ram_idx),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  sum_engine u_sum_engine (
    .clk        (FPGA_CLK3),
    .rst_n      (SYS_RST_N),
    .sum_start  (sum_start),
    .sum_done   (sum_done),
    .sum_result (sum_result),
    .mem        (eng_port.requester)
  );

  word_ram u_word_ram (
    .clk   (FPGA_CLK3),
    .en    (ram_en),
    .we    (ram_we),
    .idx   (ram_idx),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

`default_nettype wire

/* test/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// --------------------
// Reporting
// --------------------
task automatic fail_run(input string why);
  $display("%s", why);
  $display("TESTBENCH FAILED");
  $fatal(1, "Run stopped at first error");
endtask

task automatic check_value(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    fail_run($sformatf("CHECK FAILED %s expected %08h actual %08h",
                       test_name, expected, actual));
  end
endtask

// --------------------
// Model
// --------------------
function automatic logic [23:0] ram_addr(input int idx);
  return RAM_BASE | 24'(idx << 2);  // Word index to byte address
endfunction

function automatic int reg_slot(input logic [7:0] off);
  if (off == 8'h00) return 0;                                    // Run register
  if (off >= 8'h10 && off <= 8'h30 && off[1:0] == 2'b00) return int'(off[7:2]) - 3;
  return -1;                                                     // Unmapped
endfunction

function automatic void update_shadow(input logic [23:0] addr, input logic [31:0] data,
                                      input logic [3:0] byte_n);
  int slot;
  int idx;
  slot = reg_slot(addr[7:0]);
  idx  = int'(addr[10:2]);
  if (addr[15:12] == `MZ_REG_PAGE) begin
    if (slot >= 0) reg_shadow[slot] = data;                      // Full word
  end else begin
    for (int lane = 0; lane < 4; lane++) begin
      if (!byte_n[lane]) ram_shadow[idx][lane*8 +: 8] = data[lane*8 +: 8];
    end
  end
endfunction

function automatic logic [31:0] ref_read(input logic [23:0] addr);
  int slot;
  int idx;
  slot = reg_slot(addr[7:0]);
  idx  = int'(addr[10:2]);
  if (addr[15:12] == `MZ_REG_PAGE) return (slot >= 0) ? reg_shadow[slot] : 32'd0;
  if (idx == 0) return ram_shadow[1] + ram_shadow[2];            // Wrapping sum
  return ram_shadow[idx];
endfunction

// --------------------
// Bus cycles
// --------------------
task automatic wait_dtack(input logic level);
  int waited;
  waited = 0;
  @(negedge clk);
  while (bus_dtack !== level) begin
    waited++;
    if (waited > 64) fail_run("Bus cycle stalled: DTACK did not change within 64 cycles");
    @(negedge clk);
  end
endtask

task automatic bus_write(input logic [23:0] addr, input logic [31:0] data,
                         input logic [3:0] byte_n);
  @(posedge clk);
  bus_as     <= 1'b1;
  bus_rw     <= 1'b0;
  bus_addr   <= addr;
  bus_wdata  <= data;
  bus_byte_n <= byte_n;
  wait_dtack(1'b1);
  @(posedge clk);
  bus_as <= 1'b0;   // Release after DTACK
  wait_dtack(1'b0);
  update_shadow(addr, data, byte_n);
endtask

task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
  @(posedge clk);
  bus_as     <= 1'b1;
  bus_rw     <= 1'b1;
  bus_addr   <= addr;
  bus_byte_n <= 4'h0;
  wait_dtack(1'b1);
  data = bus_rdata;  // Stable while DTACK high
  if (bus_rdata_oe !== 1'b1) fail_run("Read data not enabled during an acknowledged read");
  @(posedge clk);
  bus_as <= 1'b0;
  wait_dtack(1'b0);
endtask

task automatic read_compare(input string test_name, input logic [23:0] addr);
  logic [31:0] data;
  bus_read(addr, data);
  name_q.push_back(test_name);
  exp_q.push_back(ref_read(addr));
  act_q.push_back(data);  // Last push wakes the comparer
  pushed_count++;
endtask

`endif

/* test/tb_mz_top.sv */
`default_nettype none
`include "mz_config.svh"

module tb_mz_top;
  import mz_bus_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;        // About 150 bus cycles under 100 cycles each
  localparam logic [23:0] RAM_BASE = 24'h001000;  // Page 1 selects the buffer RAM

  logic        clk;
  logic        rst_n;
  logic        bus_as;
  logic        bus_rw;
  logic [3:0]  bus_byte_n;
  logic [23:0] bus_addr;
  logic [31:0] bus_wdata;
  logic [31:0] bus_rdata;
  logic        bus_rdata_oe;
  logic        bus_dtack;
  logic        ctrl_run;

  logic [31:0] reg_shadow [10];   // Run then nine arguments
  logic [31:0] ram_shadow [512];  // Host view of the buffer RAM
  string       name_q [$];        // Pending reads for the comparer
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];
  int          pushed_count;
  int          checked_count;
  int          cycle_count;
  logic        dtack_prev;

  `include "tb_bus_tasks.svh"

  mz_top i_dut (
    .FPGA_CLK3    (clk),
    .SYS_RST_N    (rst_n),
    .bus_as       (bus_as),
    .bus_rw       (bus_rw),
    .bus_byte_n   (bus_byte_n),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .bus_rdata    (bus_rdata),
    .bus_rdata_oe (bus_rdata_oe),
    .bus_dtack    (bus_dtack),
    .ctrl_run     (ctrl_run)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // Period 4
  end

  // --------------------
  // Run limit and handshake monitor
  // --------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (bus_dtack && !dtack_prev && !bus_as) begin
        fail_run("DTACK rose while the address strobe was low");
      end
      if (!bus_dtack && dtack_prev && bus_as) begin
        fail_run("DTACK dropped while the address strobe was still high");
      end
    end
    dtack_prev <= bus_dtack;
  end

  // Compare queued reads against the model
  initial begin : compare_reads
    string       name;
    logic [31:0] expected;
    logic [31:0] actual;
    forever begin
      wait (act_q.size() > 0);
      name     = name_q.pop_front();
      expected = exp_q.pop_front();
      actual   = act_q.pop_front();
      check_value(name, expected, actual);
      checked_count++;
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin : run_tests
    logic [7:0]  reg_offs [10];
    logic [7:0]  unmapped [6];
    logic [23:0] addr;
    int          idx;
    void'($urandom(32'h5a4d));
    reg_offs = '{REG_RUN, REG_NCS, REG_NCT, REG_N1, REG_N2,
                 REG_NNOBPA, REG_NNOBPB, REG_PPPA, REG_PPPB, REG_LVL};
    unmapped = '{8'h04, 8'h08, 8'h0c, 8'h34, 8'h40, 8'hfc};
    foreach (reg_shadow[i]) reg_shadow[i] = '0;  // Registers reset to zero
    dtack_prev <= 1'b0;
    rst_n      <= 1'b0;
    bus_as     <= 1'b0;
    bus_rw     <= 1'b1;
    bus_byte_n <= 4'hf;
    bus_addr   <= '0;
    bus_wdata  <= '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset_dtack", 32'd0, {31'd0, bus_dtack});
    check_value("reset_rdata_oe", 32'd0, {31'd0, bus_rdata_oe});
    check_value("reset_ctrl_run", 32'd0, {31'd0, ctrl_run});

    foreach (reg_offs[i]) bus_write({16'h0, reg_offs[i]}, $urandom(), 4'h0);
    foreach (reg_offs[i]) read_compare("reg_readback", {16'h0, reg_offs[i]});
    foreach (unmapped[i]) read_compare("reg_unmapped", {16'h0, unmapped[i]});
    bus_write({16'h0, REG_RUN}, $urandom() | 32'h1, 4'h0);      // Start level high
    check_value("ctrl_run_set", {31'd0, reg_shadow[0][0]}, {31'd0, ctrl_run});
    bus_write({16'h0, REG_RUN}, $urandom() & ~32'h1, 4'h0);     // Start level low
    check_value("ctrl_run_clear", {31'd0, reg_shadow[0][0]}, {31'd0, ctrl_run});

    for (int k = 0; k < 12; k++) begin
      idx  = int'($urandom_range(3, 511));
      addr = ram_addr(idx);
      bus_write(addr, $urandom(), 4'h0);                        // Known full word first
      bus_write(addr, $urandom(), 4'($urandom_range(0, 15)));
      read_compare("byte_lanes", addr);
    end

    bus_write(ram_addr(1), $urandom(), 4'h0);
    bus_write(ram_addr(2), $urandom(), 4'h0);
    read_compare("sum_random", ram_addr(0));
    bus_write(ram_addr(1), $urandom() | 32'h8000_0000, 4'h0);  // Both top bits set
    bus_write(ram_addr(2), $urandom() | 32'h8000_0000, 4'h0);
    read_compare("sum_overflow", ram_addr(0));
    bus_write(ram_addr(2), $urandom(), 4'h0);                   // Only operand B changes
    read_compare("sum_rewrite", ram_addr(0));
    read_compare("sum_word_a", ram_addr(1));
    read_compare("sum_word_b", ram_addr(2));

    wait (checked_count == pushed_count);
    @(negedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
+incdir+test
hdl/mz_bus_pkg.sv
hdl/mz_mem_pkg.sv
hdl/mem_port_if.sv
hdl/mz_bus_slave.sv
hdl/ctrl_regs.sv
hdl/ram_arbiter.sv
hdl/word_ram.sv
hdl/sum_engine.sv
hdl/mz_top.sv
test/tb_mz_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mz_top
RTL_TOP   ?= mz_top
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
